// ==== fifo36_to_ll8.sv ====
`timescale 1ns/1ps

module fifo36_to_ll8
   import ll_stream_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clear_i,
   input  f36_word_t f36_i,
   input  logic      f36_src_rdy_i,
   output logic      f36_dst_rdy_o,
   output ll8_beat_t ll_o,
   output logic      ll_src_rdy_o,
   input  logic      ll_dst_rdy_i
);

   f36_word_t f36_int;
   logic      f36_src_rdy_int;
   logic      f36_dst_rdy_int;
   ll8_beat_t ll_int;
   logic      ll_src_rdy_int;
   logic      ll_dst_rdy_int;

   // head fifo keeps the unpacker from stalling the word source.
   fifo_short #(.WIDTH(F36_WIDTH)) u_head_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (f36_i),
      .src_rdy_i (f36_src_rdy_i),
      .dst_rdy_o (f36_dst_rdy_o),
      .data_o    (f36_int),
      .src_rdy_o (f36_src_rdy_int),
      .dst_rdy_i (f36_dst_rdy_int)
   );

   fifo36_unpack u_unpack (
      .clk            (clk),
      .reset          (reset),
      .clear_i        (clear_i),
      .word_i         (f36_int),
      .word_src_rdy_i (f36_src_rdy_int),
      .word_dst_rdy_o (f36_dst_rdy_int),
      .beat_o         (ll_int),
      .beat_src_rdy_o (ll_src_rdy_int),
      .beat_dst_rdy_i (ll_dst_rdy_int)
   );

   // tail fifo, breaks the ready chain to the byte sink.
   fifo_short #(.WIDTH(LL8_WIDTH)) u_tail_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (ll_int),
      .src_rdy_i (ll_src_rdy_int),
      .dst_rdy_o (ll_dst_rdy_int),
      .data_o    (ll_o),
      .src_rdy_o (ll_src_rdy_o),
      .dst_rdy_i (ll_dst_rdy_i)
   );

endmodule

// ==== fifo36_unpack.sv ====
`timescale 1ns/1ps

module fifo36_unpack
   import ll_stream_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clear_i,
   input  f36_word_t word_i,
   input  logic      word_src_rdy_i,
   output logic      word_dst_rdy_o,
   output ll8_beat_t beat_o,
   output logic      beat_src_rdy_o,
   input  logic      beat_dst_rdy_i
);

   byte_sel_e lane_q;
   logic      advance;
   logic      last_byte;

   // --------------------
   // byte select
   // --------------------

   always_comb begin
      case (lane_q)
         BYTE0:   beat_o.data = word_i.data[31:24];
         BYTE1:   beat_o.data = word_i.data[23:16];
         BYTE2:   beat_o.data = word_i.data[15:8];
         default: beat_o.data = word_i.data[7:0];
      endcase
   end

   // sof only on the first lane of a first word.
   assign beat_o.sof = word_i.sof & (lane_q == BYTE0);

   // eof where the occupancy code says the frame stops.
   always_comb begin
      case (lane_q)
         BYTE0:   beat_o.eof = word_i.eof & (word_i.occ == 2'd1);
         BYTE1:   beat_o.eof = word_i.eof & (word_i.occ == 2'd2);
         BYTE2:   beat_o.eof = word_i.eof & (word_i.occ == 2'd3);
         default: beat_o.eof = word_i.eof & (word_i.occ == OCC_FULL);
      endcase
   end

   // --------------------
   // handshake
   // --------------------

   assign beat_src_rdy_o = word_src_rdy_i;
   assign advance        = word_src_rdy_i & beat_dst_rdy_i;
   assign last_byte      = (lane_q == BYTE3) | beat_o.eof;

   // pop the word on the last byte we use from it.
   assign word_dst_rdy_o = advance & last_byte;

   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         lane_q <= BYTE0;
      end else if (advance) begin
         if (last_byte) begin
            lane_q <= BYTE0;
         end else begin
            lane_q <= byte_sel_e'(lane_q + 2'd1);
         end
      end
   end

endmodule

// ==== fifo_short.sv ====
`timescale 1ns/1ps

module fifo_short
   import ll_stream_pkg::*;
#(
   parameter int WIDTH = F36_WIDTH
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             clear_i,
   input  logic [WIDTH-1:0] data_i,
   input  logic             src_rdy_i,
   output logic             dst_rdy_o,
   output logic [WIDTH-1:0] data_o,
   output logic             src_rdy_o,
   input  logic             dst_rdy_i
);

   logic [WIDTH-1:0]         mem [2**SHORT_FIFO_AW];
   logic [SHORT_FIFO_AW-1:0] wr_ptr;
   logic [SHORT_FIFO_AW-1:0] rd_ptr;
   logic [SHORT_FIFO_AW:0]   count;
   logic                     do_write;
   logic                     do_read;

   // full exactly when the count reaches 2**aw.
   assign dst_rdy_o = ~count[SHORT_FIFO_AW];
   assign src_rdy_o = (count != '0);

   assign do_write = src_rdy_i & dst_rdy_o;
   assign do_read  = src_rdy_o & dst_rdy_i;

   // head entry straight from the array, no path from the inputs.
   assign data_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous push and pop leave the count alone.
         if (do_write && !do_read) begin
            count <= count + 1'b1;
         end else if (do_read && !do_write) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// ==== ll8_pack.sv ====
`timescale 1ns/1ps

module ll8_pack
   import ll_stream_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clear_i,
   input  ll8_beat_t beat_i,
   input  logic      beat_src_rdy_i,
   output logic      beat_dst_rdy_o,
   output f36_word_t word_o,
   output logic      word_src_rdy_o,
   input  logic      word_dst_rdy_i
);

   byte_sel_e   lane_q;
   pack_state_e state_q;
   f36_word_t   word_q;
   f36_word_t   word_next;
   logic        accept;
   logic        close_word;

   // --------------------
   // handshake
   // --------------------

   assign beat_dst_rdy_o = (state_q == FILLING);
   assign word_src_rdy_o = (state_q == HOLDING);
   assign word_o         = word_q;

   assign accept     = beat_src_rdy_i & beat_dst_rdy_o;
   assign close_word = (lane_q == BYTE3) | beat_i.eof;

   // --------------------
   // word assembly
   // --------------------

   always_comb begin
      word_next = word_q;
      // a new word starts from zero, so unused lanes stay clear.
      if (lane_q == BYTE0) begin
         word_next     = '0;
         word_next.sof = beat_i.sof;
      end
      case (lane_q)
         BYTE0:   word_next.data[31:24] = beat_i.data;
         BYTE1:   word_next.data[23:16] = beat_i.data;
         BYTE2:   word_next.data[15:8]  = beat_i.data;
         default: word_next.data[7:0]   = beat_i.data;
      endcase
      word_next.eof = beat_i.eof;
      // byte count so far, modulo 4.
      word_next.occ = lane_q + 2'd1;
   end

   always_ff @(posedge clk) begin
      if (reset || clear_i) begin
         state_q <= FILLING;
         lane_q  <= BYTE0;
         word_q  <= '0;
      end else begin
         case (state_q)
            FILLING: begin
               if (accept) begin
                  word_q <= word_next;
                  if (close_word) begin
                     state_q <= HOLDING;
                     lane_q  <= BYTE0;
                  end else begin
                     lane_q <= byte_sel_e'(lane_q + 2'd1);
                  end
               end
            end
            default: begin
               // held until the tail fifo takes it.
               if (word_dst_rdy_i) begin
                  state_q <= FILLING;
               end
            end
         endcase
      end
   end

endmodule

// ==== ll8_to_fifo36.sv ====
`timescale 1ns/1ps

module ll8_to_fifo36
   import ll_stream_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clear_i,
   input  ll8_beat_t ll_i,
   input  logic      ll_src_rdy_i,
   output logic      ll_dst_rdy_o,
   output f36_word_t f36_o,
   output logic      f36_src_rdy_o,
   input  logic      f36_dst_rdy_i
);

   ll8_beat_t ll_int;
   logic      ll_src_rdy_int;
   logic      ll_dst_rdy_int;
   f36_word_t f36_int;
   logic      f36_src_rdy_int;
   logic      f36_dst_rdy_int;

   // head fifo on the byte side.
   fifo_short #(.WIDTH(LL8_WIDTH)) u_head_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (ll_i),
      .src_rdy_i (ll_src_rdy_i),
      .dst_rdy_o (ll_dst_rdy_o),
      .data_o    (ll_int),
      .src_rdy_o (ll_src_rdy_int),
      .dst_rdy_i (ll_dst_rdy_int)
   );

   ll8_pack u_pack (
      .clk            (clk),
      .reset          (reset),
      .clear_i        (clear_i),
      .beat_i         (ll_int),
      .beat_src_rdy_i (ll_src_rdy_int),
      .beat_dst_rdy_o (ll_dst_rdy_int),
      .word_o         (f36_int),
      .word_src_rdy_o (f36_src_rdy_int),
      .word_dst_rdy_i (f36_dst_rdy_int)
   );

   // tail fifo on the word side.
   fifo_short #(.WIDTH(F36_WIDTH)) u_tail_fifo (
      .clk       (clk),
      .reset     (reset),
      .clear_i   (clear_i),
      .data_i    (f36_int),
      .src_rdy_i (f36_src_rdy_int),
      .dst_rdy_o (f36_dst_rdy_int),
      .data_o    (f36_o),
      .src_rdy_o (f36_src_rdy_o),
      .dst_rdy_i (f36_dst_rdy_i)
   );

endmodule

// ==== ll_bridge_top.sv ====
`timescale 1ns/1ps

module ll_bridge_top
   import ll_stream_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      clear_i,

   // downstream, words in and bytes out.
   input  f36_word_t dn_f36_i,
   input  logic      dn_f36_src_rdy_i,
   output logic      dn_f36_dst_rdy_o,
   output ll8_beat_t dn_ll_o,
   output logic      dn_ll_src_rdy_o,
   input  logic      dn_ll_dst_rdy_i,

   // upstream, bytes in and words out.
   input  ll8_beat_t up_ll_i,
   input  logic      up_ll_src_rdy_i,
   output logic      up_ll_dst_rdy_o,
   output f36_word_t up_f36_o,
   output logic      up_f36_src_rdy_o,
   input  logic      up_f36_dst_rdy_i
);

   fifo36_to_ll8 u_dn_path (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .f36_i         (dn_f36_i),
      .f36_src_rdy_i (dn_f36_src_rdy_i),
      .f36_dst_rdy_o (dn_f36_dst_rdy_o),
      .ll_o          (dn_ll_o),
      .ll_src_rdy_o  (dn_ll_src_rdy_o),
      .ll_dst_rdy_i  (dn_ll_dst_rdy_i)
   );

   ll8_to_fifo36 u_up_path (
      .clk           (clk),
      .reset         (reset),
      .clear_i       (clear_i),
      .ll_i          (up_ll_i),
      .ll_src_rdy_i  (up_ll_src_rdy_i),
      .ll_dst_rdy_o  (up_ll_dst_rdy_o),
      .f36_o         (up_f36_o),
      .f36_src_rdy_o (up_f36_src_rdy_o),
      .f36_dst_rdy_i (up_f36_dst_rdy_i)
   );

endmodule

// ==== ll_stream_pkg.sv ====
package ll_stream_pkg;

   // --------------------
   // stream payloads
   // --------------------

   // one word of the 36-bit fifo interface.
   // occ is only looked at on the last word of a frame.
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } f36_word_t;

   // one beat of the ll8 byte interface.
   typedef struct packed {
      logic       eof;
      logic       sof;
      logic [7:0] data;
   } ll8_beat_t;

   // bit widths, for the generic fifo.
   localparam int F36_WIDTH = 36;
   localparam int LL8_WIDTH = 10;

   // every short fifo holds 2**4 entries.
   localparam int SHORT_FIFO_AW = 4;

   // --------------------
   // occupancy rule
   // --------------------

   // all four bytes valid; 1..3 count valid bytes from the msb.
   localparam logic [1:0] OCC_FULL = 2'd0;

   // --------------------
   // converter states
   // --------------------

   // byte lane, BYTE0 is data[31:24].
   typedef enum logic [1:0] {
      BYTE0 = 2'd0,
      BYTE1 = 2'd1,
      BYTE2 = 2'd2,
      BYTE3 = 2'd3
   } byte_sel_e;

   // packer output register.
   typedef enum logic {
      FILLING = 1'b0,
      HOLDING = 1'b1
   } pack_state_e;

endpackage

// ==== project.f ====
ll_stream_pkg.sv
fifo_short.sv
fifo36_unpack.sv
ll8_pack.sv
fifo36_to_ll8.sv
ll8_to_fifo36.sv
ll_bridge_top.sv
tb_ll_bridge.sv

// ==== tb_ll_bridge.sv ====
`timescale 1ns/1ps

module tb_ll_bridge
   import ll_stream_pkg::*;
();

   localparam int SINK_READY   = 0;
   localparam int SINK_RANDOM  = 1;
   localparam int SINK_STALL   = 2;
   localparam int RAND_FRAMES  = 20;
   localparam int MAX_RAND_LEN = 16;
   // beats of each test, in the order they run.
   localparam int TOTAL_BEATS  = 4 + 48 + RAND_FRAMES * MAX_RAND_LEN + 45 + 94;
   localparam int DRAIN_LIMIT  = 1000;

   logic      clk;
   logic      reset;
   logic      clear_i;
   f36_word_t dn_f36_i;
   logic      dn_f36_src_rdy_i;
   logic      dn_f36_dst_rdy_o;
   ll8_beat_t dn_ll_o;
   logic      dn_ll_src_rdy_o;
   logic      dn_ll_dst_rdy_i;
   ll8_beat_t up_ll_i;
   logic      up_ll_src_rdy_i;
   logic      up_ll_dst_rdy_o;
   f36_word_t up_f36_o;
   logic      up_f36_src_rdy_o;
   logic      up_f36_dst_rdy_i;

   integer    seed = 38336;
   int        error_count = 0;
   int        dn_sink_mode;
   int        up_sink_mode;
   ll8_beat_t exp_beats [$];
   f36_word_t exp_words [$];

   ll_bridge_top u_dut (
      .clk              (clk),
      .reset            (reset),
      .clear_i          (clear_i),
      .dn_f36_i         (dn_f36_i),
      .dn_f36_src_rdy_i (dn_f36_src_rdy_i),
      .dn_f36_dst_rdy_o (dn_f36_dst_rdy_o),
      .dn_ll_o          (dn_ll_o),
      .dn_ll_src_rdy_o  (dn_ll_src_rdy_o),
      .dn_ll_dst_rdy_i  (dn_ll_dst_rdy_i),
      .up_ll_i          (up_ll_i),
      .up_ll_src_rdy_i  (up_ll_src_rdy_i),
      .up_ll_dst_rdy_o  (up_ll_dst_rdy_o),
      .up_f36_o         (up_f36_o),
      .up_f36_src_rdy_o (up_f36_src_rdy_o),
      .up_f36_dst_rdy_i (up_f36_dst_rdy_i)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------
   // output sinks and monitors
   // --------------------

   always @(negedge clk) begin
      case (dn_sink_mode)
         SINK_RANDOM: dn_ll_dst_rdy_i = (($random(seed) & 3) != 0);
         SINK_STALL:  dn_ll_dst_rdy_i = 1'b0;
         default:     dn_ll_dst_rdy_i = 1'b1;
      endcase
      case (up_sink_mode)
         SINK_RANDOM: up_f36_dst_rdy_i = (($random(seed) & 3) != 0);
         SINK_STALL:  up_f36_dst_rdy_i = 1'b0;
         default:     up_f36_dst_rdy_i = 1'b1;
      endcase
   end

   task automatic check_beat(input ll8_beat_t got);
      ll8_beat_t exp;
      assert (exp_beats.size() != 0) else begin
         $display("ERROR at %0t: dn_ll_o gave beat %h that no frame accounts for", $time, got);
         error_count++;
      end
      if (exp_beats.size() != 0) begin
         exp = exp_beats.pop_front();
         assert (got === exp) else begin
            $display("FAILED %0t dn_ll_o expected %h actual %h", $time, exp, got);
            error_count++;
         end
      end
   endtask

   task automatic check_word(input f36_word_t got);
      f36_word_t exp;
      assert (exp_words.size() != 0) else begin
         $display("ERROR at %0t: up_f36_o gave word %h that no frame accounts for", $time, got);
         error_count++;
      end
      if (exp_words.size() != 0) begin
         exp = exp_words.pop_front();
         assert (got === exp) else begin
            $display("FAILED %0t up_f36_o expected %h actual %h", $time, exp, got);
            error_count++;
         end
      end
   endtask

   always @(posedge clk) begin
      if (!reset && dn_ll_src_rdy_o && dn_ll_dst_rdy_i) begin
         check_beat(dn_ll_o);
      end
      if (!reset && up_f36_src_rdy_o && up_f36_dst_rdy_i) begin
         check_word(up_f36_o);
      end
   end

   task automatic check_level(input string name, input logic exp, input logic got);
      assert (got === exp) else begin
         $display("FAILED %0t %s expected %b actual %b", $time, name, exp, got);
         error_count++;
      end
   endtask

   // --------------------
   // drivers, entered just after a falling edge
   // --------------------

   task automatic send_word(input f36_word_t w, input bit gaps);
      if (gaps) begin
         while (($random(seed) & 3) == 0) begin
            @(negedge clk);
         end
      end
      dn_f36_i         = w;
      dn_f36_src_rdy_i = 1'b1;
      @(posedge clk);
      while (!dn_f36_dst_rdy_o) begin
         @(posedge clk);
      end
      @(negedge clk);
      dn_f36_src_rdy_i = 1'b0;
   endtask

   task automatic send_beat(input ll8_beat_t b, input bit gaps);
      if (gaps) begin
         while (($random(seed) & 3) == 0) begin
            @(negedge clk);
         end
      end
      up_ll_i         = b;
      up_ll_src_rdy_i = 1'b1;
      @(posedge clk);
      while (!up_ll_dst_rdy_o) begin
         @(posedge clk);
      end
      @(negedge clk);
      up_ll_src_rdy_i = 1'b0;
   endtask

   // one downstream frame; expected beats come straight from the byte list.
   task automatic send_dn_frame(input int nbytes, input bit gaps);
      logic [7:0] frame [$];
      ll8_beat_t  b;
      f36_word_t  w;
      int         nwords;
      int         idx;
      for (int i = 0; i < nbytes; i++) begin
         frame.push_back($random(seed));
         b.data = frame[i];
         b.sof  = (i == 0);
         b.eof  = (i == nbytes - 1);
         exp_beats.push_back(b);
      end
      nwords = (nbytes + 3) / 4;
      for (int wi = 0; wi < nwords; wi++) begin
         // lanes past the end of the frame carry junk.
         w.data = $random(seed);
         for (int k = 0; k < 4; k++) begin
            idx = 4 * wi + k;
            if (idx < nbytes) begin
               w.data[31 - 8 * k -: 8] = frame[idx];
            end
         end
         w.sof = (wi == 0);
         w.eof = (wi == nwords - 1);
         w.occ = w.eof ? 2'(nbytes % 4) : OCC_FULL;
         send_word(w, gaps);
      end
   endtask

   // one upstream frame; unfilled lanes of the last word are zero.
   task automatic send_up_frame(input int nbytes, input bit gaps);
      logic [7:0] frame [$];
      ll8_beat_t  b;
      f36_word_t  w;
      int         nwords;
      int         idx;
      int         cnt;
      for (int i = 0; i < nbytes; i++) begin
         frame.push_back($random(seed));
      end
      nwords = (nbytes + 3) / 4;
      for (int wi = 0; wi < nwords; wi++) begin
         w   = '0;
         cnt = 0;
         for (int k = 0; k < 4; k++) begin
            idx = 4 * wi + k;
            if (idx < nbytes) begin
               w.data[31 - 8 * k -: 8] = frame[idx];
               cnt++;
            end
         end
         w.sof = (wi == 0);
         w.eof = (wi == nwords - 1);
         w.occ = 2'(cnt % 4);
         exp_words.push_back(w);
      end
      for (int i = 0; i < nbytes; i++) begin
         b.data = frame[i];
         b.sof  = (i == 0);
         b.eof  = (i == nbytes - 1);
         send_beat(b, gaps);
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while ((exp_beats.size() + exp_words.size()) != 0 && n < DRAIN_LIMIT) begin
         @(negedge clk);
         n++;
      end
      assert ((exp_beats.size() + exp_words.size()) == 0) else begin
         $display("ERROR at %0t: %0d beats and %0d words never came out", $time,
                  exp_beats.size(), exp_words.size());
         error_count++;
         exp_beats.delete();
         exp_words.delete();
      end
   endtask

   // --------------------
   // tests
   // --------------------

   task automatic test_reset_state();
      check_level("dn_ll_src_rdy_o", 1'b0, dn_ll_src_rdy_o);
      check_level("up_f36_src_rdy_o", 1'b0, up_f36_src_rdy_o);
      check_level("dn_f36_dst_rdy_o", 1'b1, dn_f36_dst_rdy_o);
      check_level("up_ll_dst_rdy_o", 1'b1, up_ll_dst_rdy_o);
   endtask

   task automatic test_single_word();
      send_dn_frame(4, 1'b0);
      wait_drain();
   endtask

   task automatic test_partial_words();
      int lens [6] = '{5, 6, 7, 9, 10, 11};
      foreach (lens[i]) begin
         send_dn_frame(lens[i], 1'b0);
         wait_drain();
      end
   endtask

   task automatic test_random_stream();
      int len;
      dn_sink_mode = SINK_RANDOM;
      repeat (RAND_FRAMES) begin
         len = 1 + ($unsigned($random(seed)) % MAX_RAND_LEN);
         send_dn_frame(len, 1'b1);
      end
      wait_drain();
      dn_sink_mode = SINK_READY;
   endtask

   task automatic test_upstream_pack();
      up_sink_mode = SINK_RANDOM;
      for (int n = 1; n <= 9; n++) begin
         send_up_frame(n, 1'b1);
      end
      wait_drain();
      up_sink_mode = SINK_READY;
   endtask

   task automatic test_clear_midframe();
      f36_word_t w;
      ll8_beat_t b;
      int        n;
      dn_sink_mode = SINK_STALL;
      up_sink_mode = SINK_STALL;
      @(negedge clk);
      // a one-byte frame, then a long frame that backs up both fifos.
      // the unpacker is left stalled part way through a word.
      w.occ  = 2'd1;
      w.eof  = 1'b1;
      w.sof  = 1'b1;
      w.data = $random(seed);
      send_word(w, 1'b0);
      w.occ = OCC_FULL;
      w.eof = 1'b0;
      for (int i = 0; i < 19; i++) begin
         w.sof  = (i == 0);
         w.data = $random(seed);
         send_word(w, 1'b0);
      end
      // five bytes leave the packer part way through its second word.
      for (int i = 0; i < 5; i++) begin
         b.data = $random(seed);
         b.sof  = (i == 0);
         b.eof  = 1'b0;
         send_beat(b, 1'b0);
      end
      n = 0;
      while (!(dn_ll_src_rdy_o && up_f36_src_rdy_o && !dn_f36_dst_rdy_o) && n < 50) begin
         @(negedge clk);
         n++;
      end
      assert (dn_ll_src_rdy_o && up_f36_src_rdy_o && !dn_f36_dst_rdy_o) else begin
         $display("ERROR at %0t: partial frames never backed up to the outputs", $time);
         error_count++;
      end
      clear_i = 1'b1;
      @(negedge clk);
      clear_i = 1'b0;
      check_level("dn_ll_src_rdy_o", 1'b0, dn_ll_src_rdy_o);
      check_level("up_f36_src_rdy_o", 1'b0, up_f36_src_rdy_o);
      dn_sink_mode = SINK_READY;
      up_sink_mode = SINK_READY;
      send_dn_frame(6, 1'b0);
      send_up_frame(6, 1'b0);
      wait_drain();
   endtask

   // --------------------
   // main sequence and watchdog
   // --------------------

   initial begin
      reset            = 1'b1;
      clear_i          = 1'b0;
      dn_f36_i         = '0;
      dn_f36_src_rdy_i = 1'b0;
      dn_ll_dst_rdy_i  = 1'b1;
      up_ll_i          = '0;
      up_ll_src_rdy_i  = 1'b0;
      up_f36_dst_rdy_i = 1'b1;
      dn_sink_mode     = SINK_READY;
      up_sink_mode     = SINK_READY;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      test_reset_state();
      test_single_word();
      test_partial_words();
      test_random_stream();
      test_upstream_pack();
      test_clear_midframe();
      // a few idle cycles to catch stray output.
      repeat (10) @(negedge clk);
      $display("tests done, %0d errors", error_count);
      if (error_count == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   initial begin
      repeat (TOTAL_BEATS * 20) @(posedge clk);
      $display("ERROR: timeout after %0d cycles, the bridge stopped moving data, %0d errors",
               TOTAL_BEATS * 20, error_count);
      $display("Simulation FAILED");
      $finish;
   end

endmodule
